// ==== colorMapper.sv ====
// layer compositing, background bands, palette lookup, sync delay
module colorMapper (
	input  logic            clk,
	input  logic            rstN,
	scanIf.sink             scan,
	input  logic            hSyncIn,
	input  logic            vSyncIn,
	input  gamePkg::pixIdxT cursorIdx,
	input  gamePkg::pixIdxT dogIdx,
	output logic [3:0]      vgaR,
	output logic [3:0]      vgaG,
	output logic [3:0]      vgaB,
	output logic            hSync,
	output logic            vSync
);

	// syncs ride alongside the colour
	logic [gamePkg::pipeDepth-1:0] hsPipe, vsPipe;
	logic blankD1;
	gamePkg::coordT rowD1;
	gamePkg::rgbT pixelRgb, rgbOut;

	// stage 1 lines up with the layer indices, one pixel late
	always_comb begin
		if (blankD1)
			pixelRgb = '0;
		else if (cursorIdx != '0)
			pixelRgb = gamePkg::palette[cursorIdx];
		else if (dogIdx != '0)
			pixelRgb = gamePkg::palette[dogIdx];
		else if (rowD1 < gamePkg::groundY)
			pixelRgb = gamePkg::bgSky;
		else
			pixelRgb = gamePkg::bgGround;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			hsPipe  <= '1;
			vsPipe  <= '1;
			blankD1 <= 1'b1;
			rgbOut  <= '0;
		end else if (scan.tick) begin
			hsPipe  <= {hsPipe[gamePkg::pipeDepth-2:0], hSyncIn};
			vsPipe  <= {vsPipe[gamePkg::pipeDepth-2:0], vSyncIn};
			blankD1 <= scan.blank;
			// stage 2, pin register
			rgbOut  <= pixelRgb;
		end
	end

	always_ff @(posedge clk) begin
		if (scan.tick)
			rowD1 <= scan.drawY;
	end

	assign vgaR  = rgbOut[11:8];
	assign vgaG  = rgbOut[7:4];
	assign vgaB  = rgbOut[3:0];
	assign hSync = hsPipe[gamePkg::pipeDepth-1];
	assign vSync = vsPipe[gamePkg::pipeDepth-1];

endmodule

// ==== cursorLayer.sv ====
// mouse cursor position, clamping, per-frame latch and sprite fetch
module cursorLayer (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic signed [7:0]     mouseX,
	input  logic signed [7:0]     mouseY,
	input  logic                  mouseValid,
	scanIf.sink                   scan,
	spriteBusIf.requester         mem,
	output gamePkg::pixIdxT       cursorIdx
);

	gamePkg::coordT posX, posY;
	gamePkg::coordT frameX, frameY;
	gamePkg::coordT relX, relY;
	gamePkg::memAddrT newAddr, heldAddr;
	gamePkg::pixIdxT fetchIdx;
	logic inBox;
	logic pending;

	// add a signed delta, keep result in [0, maxPos]
	function automatic gamePkg::coordT clampAdd(input gamePkg::coordT pos,
			input logic signed [7:0] delta, input int maxPos);
		logic signed [11:0] sum;
		sum = $signed({2'b00, pos}) + $signed({{4{delta[7]}}, delta});
		if (sum < 0)
			return '0;
		else if (sum > maxPos)
			return gamePkg::coordT'(maxPos);
		else
			return sum[9:0];
	endfunction

	// ========================================
	// position
	// ========================================
	always_ff @(posedge clk) begin
		if (!rstN) begin
			posX   <= '0;
			posY   <= '0;
			frameX <= '0;
			frameY <= '0;
		end else begin
			if (mouseValid) begin
				posX <= clampAdd(posX, mouseX, gamePkg::cursorMaxX);
				posY <= clampAdd(posY, mouseY, gamePkg::cursorMaxY);
			end
			// whole frame drawn from one position
			if (scan.frameStart) begin
				frameX <= posX;
				frameY <= posY;
			end
		end
	end

	// ========================================
	// fetch
	// ========================================
	assign relX = scan.drawX - frameX;
	assign relY = scan.drawY - frameY;
	assign inBox = !scan.blank &&
		scan.drawX >= frameX && scan.drawX < frameX + gamePkg::spriteSize &&
		scan.drawY >= frameY && scan.drawY < frameY + gamePkg::spriteSize;
	assign newAddr = gamePkg::memAddrT'(gamePkg::cursorBase) +
		{2'b00, relY[3:0], relX[3:0]};

	// new request on tick, else hold until granted
	assign mem.req  = scan.tick ? inBox : pending;
	assign mem.addr = scan.tick ? newAddr : heldAddr;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending  <= 1'b0;
			fetchIdx <= '0;
		end else begin
			pending <= mem.req && !mem.gnt;
			if (scan.tick && !inBox)
				fetchIdx <= '0;
			else if (mem.rdValid)
				fetchIdx <= mem.rdData;
		end
	end

	always_ff @(posedge clk) begin
		if (scan.tick)
			heldAddr <= newAddr;
	end

	// late return lands on the next tick, pass it straight on
	assign cursorIdx = mem.rdValid ? mem.rdData : fetchIdx;

endmodule

// ==== dogLayer.sv ====
// walking dog position, animation page and sprite fetch
module dogLayer (
	input  logic            clk,
	input  logic            rstN,
	input  logic            run,
	scanIf.sink             scan,
	spriteBusIf.requester   mem,
	output gamePkg::pixIdxT dogIdx
);

	gamePkg::coordT dogX, stepX, wrapX;
	gamePkg::coordT relX, relY;
	gamePkg::memAddrT pageBase, newAddr, heldAddr;
	gamePkg::pixIdxT fetchIdx;
	logic [$clog2(gamePkg::animDiv)-1:0] animCnt;
	logic dogPage;
	logic inBox;
	logic pending;

	// ========================================
	// motion and animation
	// ========================================
	assign stepX = dogX + gamePkg::coordT'(gamePkg::dogStep);
	// wrap back to the left edge
	assign wrapX = (stepX >= gamePkg::hVisible) ?
		stepX - gamePkg::coordT'(gamePkg::hVisible) : stepX;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			dogX    <= '0;
			dogPage <= 1'b0;
			animCnt <= '0;
		end else if (scan.frameStart && run) begin
			dogX <= wrapX;
			if (animCnt == gamePkg::animDiv - 1) begin
				animCnt <= '0;
				dogPage <= !dogPage;
			end else begin
				animCnt <= animCnt + 1'b1;
			end
		end
	end

	// ========================================
	// fetch
	// ========================================
	assign relX = scan.drawX - dogX;
	assign relY = scan.drawY - gamePkg::coordT'(gamePkg::dogY);
	// no horizontal wrap, blank cuts off past column 639
	assign inBox = !scan.blank &&
		scan.drawX >= dogX && scan.drawX < dogX + gamePkg::spriteSize &&
		scan.drawY >= gamePkg::dogY && scan.drawY < gamePkg::dogY + gamePkg::spriteSize;
	assign pageBase = dogPage ? gamePkg::memAddrT'(gamePkg::dogBase1) :
		gamePkg::memAddrT'(gamePkg::dogBase0);
	assign newAddr = pageBase + {2'b00, relY[3:0], relX[3:0]};

	assign mem.req  = scan.tick ? inBox : pending;
	assign mem.addr = scan.tick ? newAddr : heldAddr;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pending  <= 1'b0;
			fetchIdx <= '0;
		end else begin
			pending <= mem.req && !mem.gnt;
			if (scan.tick && !inBox)
				fetchIdx <= '0;
			else if (mem.rdValid)
				fetchIdx <= mem.rdData;
		end
	end

	always_ff @(posedge clk) begin
		if (scan.tick)
			heldAddr <= newAddr;
	end

	assign dogIdx = mem.rdValid ? mem.rdData : fetchIdx;

endmodule

// ==== gameIfs.sv ====
// scan interface and sprite memory bus interface

// raster position broadcast from the timing block
interface scanIf;
	logic          tick;
	gamePkg::coordT drawX;
	gamePkg::coordT drawY;
	logic          blank;
	logic          frameStart;

	modport source (output tick, output drawX, output drawY, output blank,
		output frameStart);
	modport sink (input tick, input drawX, input drawY, input blank,
		input frameStart);
endinterface

// one per sprite layer, read only
interface spriteBusIf;
	logic             req;
	gamePkg::memAddrT addr;
	logic             gnt;
	gamePkg::pixIdxT  rdData;
	// one clock behind gnt
	logic             rdValid;

	modport requester (output req, output addr, input gnt, input rdData,
		input rdValid);
	modport arbiter (input req, input addr, output gnt, output rdData,
		output rdValid);
endinterface

// ==== gamePkg.sv ====
// shared types, screen timing, sprite layout, palette and motion constants
package gamePkg;

	// ========================================
	// screen timing, 640x480 at one pixel per tick
	// ========================================
	localparam int hVisible = 640;
	localparam int hFront   = 16;
	localparam int hSyncLen = 96;
	localparam int hTotal   = 800;
	localparam int vVisible = 480;
	localparam int vFront   = 10;
	localparam int vSyncLen = 2;
	localparam int vTotal   = 525;

	typedef logic [9:0]  coordT;
	typedef logic [9:0]  memAddrT;
	// palette index, 0 is see-through
	typedef logic [3:0]  pixIdxT;
	typedef logic [11:0] rgbT;

	// ========================================
	// sprite memory pages, 256 words each
	// ========================================
	localparam int spriteSize  = 16;
	localparam int spriteWords = 768;
	localparam int dogBase0    = 0;
	localparam int dogBase1    = 256;
	localparam int cursorBase  = 512;

	// 4-bit rgb per entry, entry 0 never shown
	localparam rgbT palette [16] = '{
		12'h000, 12'hFFF, 12'h000, 12'h842, 12'hA63, 12'hC94, 12'hEDB, 12'hF00,
		12'h0F0, 12'h00F, 12'hFF0, 12'h0FF, 12'hF0F, 12'h888, 12'h444, 12'hFA0
	};

	// background bands
	localparam rgbT bgSky    = 12'h6AF;
	localparam rgbT bgGround = 12'h4A2;
	localparam int  groundY  = 400;

	// motion
	localparam int cursorMaxX = 624;
	localparam int cursorMaxY = 464;
	localparam int dogStep    = 2;
	localparam int dogY       = 384;
	localparam int animDiv    = 8;

	// ticks from counters to vga pins
	localparam int pipeDepth  = 2;

endpackage

// ==== gameTop.f ====
gamePkg.sv
gameIfs.sv
vgaTiming.sv
cursorLayer.sv
dogLayer.sv
spriteArbiter.sv
spriteMem.sv
colorMapper.sv
gameTop.sv
tbChecker.sv
tbGameTop.sv

// ==== gameTop.sv ====
// renderer top level, timing, two sprite layers, shared sprite memory, colour out
module gameTop (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic signed [7:0]     mouseX,
	input  logic signed [7:0]     mouseY,
	input  logic                  mouseValid,
	input  logic                  run,
	input  logic                  loadEn,
	input  gamePkg::memAddrT      loadAddr,
	input  gamePkg::pixIdxT       loadData,
	output logic [3:0]            vgaR,
	output logic [3:0]            vgaG,
	output logic [3:0]            vgaB,
	output logic                  hSync,
	output logic                  vSync
);

	logic hSyncRaw, vSyncRaw;
	logic memWe;
	gamePkg::memAddrT memAddr;
	gamePkg::pixIdxT memWData, memRData;
	gamePkg::pixIdxT cursorIdx, dogIdx;

	scanIf      scan ();
	spriteBusIf cursorBus ();
	spriteBusIf dogBus ();

	// ========================================
	// raster and layers
	// ========================================
	vgaTiming vgaTiming_i (.clk, .rstN, .hSync(hSyncRaw), .vSync(vSyncRaw),
		.scan(scan));

	cursorLayer cursorLayer_i (.clk, .rstN, .mouseX, .mouseY, .mouseValid,
		.scan(scan), .mem(cursorBus), .cursorIdx);

	dogLayer dogLayer_i (.clk, .rstN, .run, .scan(scan), .mem(dogBus), .dogIdx);

	// ========================================
	// sprite memory
	// ========================================
	spriteArbiter spriteArbiter_i (.clk, .rstN, .loadEn, .loadAddr, .loadData,
		.cursorBus(cursorBus), .dogBus(dogBus),
		.memWe, .memAddr, .memWData, .memRData);

	spriteMem spriteMem_i (.clk, .we(memWe), .addr(memAddr), .wData(memWData),
		.rData(memRData));

	// output stage
	colorMapper colorMapper_i (.clk, .rstN, .scan(scan),
		.hSyncIn(hSyncRaw), .vSyncIn(vSyncRaw), .cursorIdx, .dogIdx,
		.vgaR, .vgaG, .vgaB, .hSync, .vSync);

endmodule

// ==== spriteArbiter.sv ====
// sprite memory arbiter, loader first, then round robin over two layers
module spriteArbiter (
	input  logic             clk,
	input  logic             rstN,
	input  logic             loadEn,
	input  gamePkg::memAddrT loadAddr,
	input  gamePkg::pixIdxT  loadData,
	spriteBusIf.arbiter      cursorBus,
	spriteBusIf.arbiter      dogBus,
	output logic             memWe,
	output gamePkg::memAddrT memAddr,
	output gamePkg::pixIdxT  memWData,
	input  gamePkg::pixIdxT  memRData
);

	logic cursorGnt, dogGnt;
	// dog wins the next conflict when set
	logic rrDog;
	logic ownerCursor, ownerDog;

	always_comb begin
		cursorGnt = 1'b0;
		dogGnt    = 1'b0;
		// reads stall for the whole load
		if (!loadEn) begin
			if (cursorBus.req && dogBus.req) begin
				dogGnt    = rrDog;
				cursorGnt = !rrDog;
			end else begin
				cursorGnt = cursorBus.req;
				dogGnt    = dogBus.req;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rrDog       <= 1'b0;
			ownerCursor <= 1'b0;
			ownerDog    <= 1'b0;
		end else begin
			if (cursorGnt)
				rrDog <= 1'b1;
			else if (dogGnt)
				rrDog <= 1'b0;
			// read data returns next clock
			ownerCursor <= cursorGnt;
			ownerDog    <= dogGnt;
		end
	end

	assign memWe    = loadEn;
	assign memWData = loadData;
	assign memAddr  = loadEn ? loadAddr : (dogGnt ? dogBus.addr : cursorBus.addr);

	assign cursorBus.gnt     = cursorGnt;
	assign dogBus.gnt        = dogGnt;
	assign cursorBus.rdData  = memRData;
	assign dogBus.rdData     = memRData;
	assign cursorBus.rdValid = ownerCursor;
	assign dogBus.rdValid    = ownerDog;

	singleGrant: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({cursorBus.gnt, dogBus.gnt, loadEn}))
		else $error("sprite memory granted twice");

	cursorReturn: assert property (@(posedge clk) disable iff (!rstN)
		cursorBus.rdValid == $past(cursorBus.gnt))
		else $error("cursor rdValid not one clock after grant");

	dogReturn: assert property (@(posedge clk) disable iff (!rstN)
		dogBus.rdValid == $past(dogBus.gnt))
		else $error("dog rdValid not one clock after grant");

endmodule

// ==== spriteMem.sv ====
// single port sprite ram, one clock read latency
module spriteMem (
	input  logic             clk,
	input  logic             we,
	input  gamePkg::memAddrT addr,
	input  gamePkg::pixIdxT  wData,
	output gamePkg::pixIdxT  rData
);

	// dog frame 0, dog frame 1, cursor
	gamePkg::pixIdxT ram [gamePkg::spriteWords];

	always_ff @(posedge clk) begin
		if (we)
			ram[addr] <= wData;
		// old data on a write cycle
		rData <= ram[addr];
	end

endmodule

// ==== tbChecker.sv ====
// reference model of raster, cursor, dog and compositing, output comparison and error counts
module tbChecker (
	input  logic              clk,
	input  logic              rstN,
	input  logic signed [7:0] mouseX,
	input  logic signed [7:0] mouseY,
	input  logic              mouseValid,
	input  logic              run,
	input  logic              loadEn,
	input  logic [9:0]        loadAddr,
	input  logic [3:0]        loadData,
	input  logic [3:0]        vgaR,
	input  logic [3:0]        vgaG,
	input  logic [3:0]        vgaB,
	input  logic              hSync,
	input  logic              vSync,
	output int                rgbErrors,
	output int                hSyncErrors,
	output int                vSyncErrors,
	output int                checkedPixels,
	output int                frameCount
);
	timeunit 1ns;
	timeprecision 100ps;

	typedef struct packed {
		logic [11:0] rgb;
		logic        hs;
		logic        vs;
	} expT;

	logic [3:0] spriteCopy [gamePkg::spriteWords];
	int hc, vc;
	bit tick;
	int curX, curY, frameCurX, frameCurY;
	int dogX, animCount;
	bit dogPage;
	int printed;
	// expected pixels still inside the output pipeline
	expT inFlight [$];

	function automatic int clampPos(input int p, input int hi);
		if (p < 0)
			return 0;
		if (p > hi)
			return hi;
		return p;
	endfunction

	// expected sync and colour for one raster position
	function automatic expT expectPixel(input int x, input int y);
		expT e;
		int cIdx;
		int dIdx;
		int base;
		cIdx = 0;
		dIdx = 0;
		e.hs = !(x >= gamePkg::hVisible + gamePkg::hFront &&
			x < gamePkg::hVisible + gamePkg::hFront + gamePkg::hSyncLen);
		e.vs = !(y >= gamePkg::vVisible + gamePkg::vFront &&
			y < gamePkg::vVisible + gamePkg::vFront + gamePkg::vSyncLen);
		e.rgb = 12'h000;
		if (x < gamePkg::hVisible && y < gamePkg::vVisible) begin
			if (x >= frameCurX && x < frameCurX + gamePkg::spriteSize &&
				y >= frameCurY && y < frameCurY + gamePkg::spriteSize)
				cIdx = spriteCopy[gamePkg::cursorBase +
					(y - frameCurY) * gamePkg::spriteSize + (x - frameCurX)];
			base = dogPage ? gamePkg::dogBase1 : gamePkg::dogBase0;
			if (x >= dogX && x < dogX + gamePkg::spriteSize &&
				y >= gamePkg::dogY && y < gamePkg::dogY + gamePkg::spriteSize)
				dIdx = spriteCopy[base + (y - gamePkg::dogY) * gamePkg::spriteSize + (x - dogX)];
			// cursor over dog over background
			if (cIdx != 0)
				e.rgb = gamePkg::palette[cIdx];
			else if (dIdx != 0)
				e.rgb = gamePkg::palette[dIdx];
			else if (y < gamePkg::groundY)
				e.rgb = gamePkg::bgSky;
			else
				e.rgb = gamePkg::bgGround;
		end
		return e;
	endfunction

	task automatic reportMismatch(input string name, input logic [11:0] expV,
			input logic [11:0] gotV);
		if (printed < 50)
			$display("mismatch time %0t: %s expected %h actual %h", $time, name, expV, gotV);
		else if (printed == 50)
			$display("more mismatches, counted without printing");
		printed++;
	endtask

	// ========================================
	// model state, advanced on the rising edge
	// ========================================
	always @(posedge clk) begin
		if (!rstN) begin
			hc = 0;
			vc = 0;
			tick = 1'b0;
			curX = 0;
			curY = 0;
			frameCurX = 0;
			frameCurY = 0;
			dogX = 0;
			animCount = 0;
			dogPage = 1'b0;
			frameCount = 0;
			inFlight.delete();
		end else begin
			if (loadEn)
				spriteCopy[loadAddr] = loadData;
			if (tick) begin
				// last pixel of the frame, positions taken before this edge's mouse step
				if (hc == gamePkg::hTotal - 1 && vc == gamePkg::vTotal - 1) begin
					frameCurX = curX;
					frameCurY = curY;
					if (run) begin
						dogX = (dogX + gamePkg::dogStep) % gamePkg::hVisible;
						animCount++;
						if (animCount == gamePkg::animDiv) begin
							animCount = 0;
							dogPage = !dogPage;
						end
					end
					frameCount++;
				end
				hc = (hc + 1) % gamePkg::hTotal;
				if (hc == 0)
					vc = (vc + 1) % gamePkg::vTotal;
			end
			tick = !tick;
			if (mouseValid) begin
				curX = clampPos(curX + int'(mouseX), gamePkg::cursorMaxX);
				curY = clampPos(curY + int'(mouseY), gamePkg::cursorMaxY);
			end
		end
	end

	// ========================================
	// compare mid cycle, pixel from pipeDepth ticks back
	// ========================================
	always @(negedge clk) begin
		expT old;
		if (rstN && tick) begin
			inFlight.push_back(expectPixel(hc, vc));
			if (inFlight.size() > gamePkg::pipeDepth) begin
				old = inFlight.pop_front();
				// frame 0 holds the sprite load
				if (frameCount >= 1) begin
					checkedPixels++;
					if (old.rgb !== {vgaR, vgaG, vgaB}) begin
						rgbErrors++;
						reportMismatch("{vgaR,vgaG,vgaB}", old.rgb, {vgaR, vgaG, vgaB});
					end
					if (old.hs !== hSync) begin
						hSyncErrors++;
						reportMismatch("hSync", {11'd0, old.hs}, {11'd0, hSync});
					end
					if (old.vs !== vSync) begin
						vSyncErrors++;
						reportMismatch("vSync", {11'd0, old.vs}, {11'd0, vSync});
					end
				end
			end
		end
	end

	initial begin
		rgbErrors = 0;
		hSyncErrors = 0;
		vSyncErrors = 0;
		checkedPixels = 0;
		frameCount = 0;
		printed = 0;
	end

endmodule

// ==== tbGameTop.sv ====
// testbench top: clock, reset, xorshift stimulus, sprite load, watchdog, DUT and checker
module tbGameTop;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkPeriod = 100;
	localparam int resetCycles = 16;
	localparam int runFrames = 6;
	// two clocks per pixel
	localparam longint frameClocks = 2 * gamePkg::hTotal * gamePkg::vTotal;
	localparam longint timeoutClocks = resetCycles + runFrames * frameClocks + 20000;

	logic clk;
	logic rstN;
	logic signed [7:0] mouseX, mouseY;
	logic mouseValid, run, loadEn;
	gamePkg::memAddrT loadAddr;
	gamePkg::pixIdxT loadData;
	logic [3:0] vgaR, vgaG, vgaB;
	logic hSync, vSync;
	int rgbErrors, hSyncErrors, vSyncErrors, checkedPixels, frameCount;
	logic [31:0] rng;

	always #(clkPeriod / 2) clk = !clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic drawRandom();
		rng = xorshift32(rng);
	endtask

	// inputs change just after the edge
	task automatic nextCycle();
		@(posedge clk);
		#5;
	endtask

	task automatic mousePulse(input logic signed [7:0] dx, input logic signed [7:0] dy);
		nextCycle();
		mouseX = dx;
		mouseY = dy;
		mouseValid = 1'b1;
		nextCycle();
		mouseValid = 1'b0;
	endtask

	// ========================================
	// stimulus pieces
	// ========================================
	task automatic loadSprites();
		for (int a = 0; a < gamePkg::spriteWords; a++) begin
			drawRandom();
			loadEn = 1'b1;
			loadAddr = gamePkg::memAddrT'(a);
			// about a quarter of the words transparent
			loadData = (rng[5:4] == 2'd0) ? 4'd0 : rng[3:0];
			nextCycle();
		end
		loadEn = 1'b0;
	endtask

	// full range deltas, runs into all four edges
	task automatic wanderMouse();
		repeat (200) begin
			drawRandom();
			mousePulse(rng[7:0], rng[15:8]);
			repeat (rng[20:16]) nextCycle();
		end
	endtask

	// pin to the top left corner, then step down onto the dog row
	task automatic aimAtDog();
		repeat (6) mousePulse(8'sh80, 8'sh80);
		repeat (3) mousePulse(8'sd0, 8'sd127);
		drawRandom();
		mousePulse({5'd0, rng[2:0]}, {4'd0, rng[7:4]});
	endtask

	gameTop gameTop_i (.*);

	tbChecker tbChecker_i (.*);

	initial begin
		int f;
		clk = 1'b0;
		rstN = 1'b0;
		mouseX = '0;
		mouseY = '0;
		mouseValid = 1'b0;
		run = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		rng = 32'd1;
		repeat (resetCycles) @(posedge clk);
		#5;
		rstN = 1'b1;
		loadSprites();
		while (frameCount < runFrames) begin
			f = frameCount;
			drawRandom();
			run = (rng[1:0] != 2'd0);
			if (f % 2 == 0)
				wanderMouse();
			else
				aimAtDog();
			wait (frameCount != f);
			nextCycle();
		end
		$display("errors: rgb %0d, hSync %0d, vSync %0d, pixels checked %0d",
			rgbErrors, hSyncErrors, vSyncErrors, checkedPixels);
		if (checkedPixels == 0)
			$display("no pixel was compared");
		if (rgbErrors + hSyncErrors + vSyncErrors == 0 && checkedPixels > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog, six frames plus margin
	initial begin
		#(timeoutClocks * clkPeriod);
		$display("timeout: run did not end within %0d clocks", timeoutClocks);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== vgaTiming.sv ====
// pixel strobe, raster counters, syncs and blank
module vgaTiming (
	input  logic clk,
	input  logic rstN,
	output logic hSync,
	output logic vSync,
	scanIf.source scan
);

	logic tickReg;
	gamePkg::coordT hCount;
	gamePkg::coordT vCount;

	// half rate strobe that the counters move on
	always_ff @(posedge clk) begin
		if (!rstN) begin
			tickReg <= 1'b0;
			hCount  <= '0;
			vCount  <= '0;
		end else begin
			tickReg <= !tickReg;
			if (tickReg) begin
				if (hCount == gamePkg::hTotal - 1) begin
					hCount <= '0;
					// next line on column wrap
					if (vCount == gamePkg::vTotal - 1)
						vCount <= '0;
					else
						vCount <= vCount + 1'b1;
				end else begin
					hCount <= hCount + 1'b1;
				end
			end
		end
	end

	// active low inside the sync intervals
	assign hSync = !(hCount >= gamePkg::hVisible + gamePkg::hFront &&
		hCount < gamePkg::hVisible + gamePkg::hFront + gamePkg::hSyncLen);
	assign vSync = !(vCount >= gamePkg::vVisible + gamePkg::vFront &&
		vCount < gamePkg::vVisible + gamePkg::vFront + gamePkg::vSyncLen);

	assign scan.tick  = tickReg;
	assign scan.drawX = hCount;
	assign scan.drawY = vCount;
	assign scan.blank = (hCount >= gamePkg::hVisible) || (vCount >= gamePkg::vVisible);
	// last pixel of the frame where both counters wrap
	assign scan.frameStart = tickReg && (hCount == gamePkg::hTotal - 1) &&
		(vCount == gamePkg::vTotal - 1);

	countRange: assert property (@(posedge clk) disable iff (!rstN)
		(hCount < gamePkg::hTotal) && (vCount < gamePkg::vTotal))
		else $error("raster counter out of range");

endmodule
